// File: Bender.yml
package:
  name: ft_test

sources:
  - rtl/ft_test_pkg.sv
  - rtl/frame_parser.sv
  - rtl/test_checker.sv
  - rtl/reply_writer.sv
  - rtl/ft_test_top.sv
  - target: test
    files:
      - test/ft_test_tb.sv

// File: ft_test_top.f
rtl/ft_test_pkg.sv
rtl/frame_parser.sv
rtl/test_checker.sv
rtl/reply_writer.sv
rtl/ft_test_top.sv
test/ft_test_tb.sv

// File: rtl/frame_parser.sv
`timescale 1ns/100ps

module frame_parser import ft_test_pkg::*; (
    input  logic   clk,
    input  logic   reset_i,
    // Input FIFO
    input  logic   in_empty_i,
    input  byte_t  in_data_i,
    output logic   in_rd_en_o,
    // Flow control from writer and checker
    input  logic   hold_i,
    input  logic   drain_i,
    // Header strobe
    output logic   hdr_valid_o,
    output cmd_t   hdr_cmd_o,
    output len_t   hdr_len_o,
    // Payload strobe
    output logic   pay_valid_o,
    output cmd_t   pay_cmd_o,
    output byte_t  pay_byte_o,
    output count_t pay_remaining_o
);

    typedef enum logic [1:0] {
        ST_CMD,
        ST_LEN_HI,
        ST_LEN_LO,
        ST_PAYLOAD
    } frame_state_e;

    frame_state_e state;
    // Command of the packet being read
    cmd_t cur_cmd;
    // Payload bytes still to come
    count_t remaining;
    // Byte taken into the frame machine this cycle
    logic consume;

    // ========================================
    // Read pacing
    // ========================================

    // Enable for one cycle, byte is on in_data_i while it is high
    // Then one idle cycle, so at most one read per two cycles
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            in_rd_en_o <= 1'b0;
        end else if (in_rd_en_o) begin
            in_rd_en_o <= 1'b0;
        end else if (!in_empty_i && !hold_i) begin
            in_rd_en_o <= 1'b1;
        end
    end

    // Drain mode reads and throws away
    assign consume = in_rd_en_o && !drain_i;

    // ========================================
    // Frame machine
    // ========================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state <= ST_CMD;
        end else if (consume) begin
            case (state)
                ST_CMD: begin
                    // Long form, length in the next two bytes
                    if (in_data_i[LEN_W-1]) begin
                        state <= ST_LEN_HI;
                    end else if (in_data_i[LEN_W-2:0] != '0) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_LEN_HI: begin
                    state <= ST_LEN_LO;
                end
                ST_LEN_LO: begin
                    // Zero long length, no payload
                    if ({remaining[COUNT_W-1:BYTE_W], in_data_i} == '0) begin
                        state <= ST_CMD;
                    end else begin
                        state <= ST_PAYLOAD;
                    end
                end
                default: begin
                    if (remaining == count_t'(1)) begin
                        state <= ST_CMD;
                    end
                end
            endcase
        end
    end

    // Command and byte counter
    always_ff @(posedge clk) begin
        if (consume) begin
            case (state)
                ST_CMD: begin
                    cur_cmd <= in_data_i[BYTE_W-1 -: CMD_W];
                    remaining <= count_t'(in_data_i[LEN_W-2:0]);
                end
                // Big endian length
                ST_LEN_HI: remaining[COUNT_W-1:BYTE_W] <= in_data_i;
                ST_LEN_LO: remaining[BYTE_W-1:0] <= in_data_i;
                default: remaining <= remaining - count_t'(1);
            endcase
        end
    end

    // ========================================
    // Strobes, valid in the consume cycle
    // ========================================

    assign hdr_valid_o = consume && (state == ST_CMD);
    assign hdr_cmd_o = in_data_i[BYTE_W-1 -: CMD_W];
    assign hdr_len_o = in_data_i[LEN_W-1:0];

    assign pay_valid_o = consume && (state == ST_PAYLOAD);
    assign pay_cmd_o = cur_cmd;
    assign pay_byte_o = in_data_i;
    // Counts down to 1 on the last byte
    assign pay_remaining_o = remaining;

endmodule

// File: rtl/ft_test_pkg.sv
package ft_test_pkg;

    // ========================================
    // Widths
    // ========================================

    // One byte on the FIFO bus
    localparam int BYTE_W = 8;
    // Header split: command on top, length below
    localparam int CMD_W = 3;
    localparam int LEN_W = 5;
    // Payload and packet counters
    localparam int COUNT_W = 16;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [CMD_W-1:0] cmd_t;
    typedef logic [LEN_W-1:0] len_t;
    typedef logic [COUNT_W-1:0] count_t;

    // ========================================
    // Commands
    // ========================================

    // Host to FPGA
    localparam cmd_t CMD_HOST_START = 3'd1;
    localparam cmd_t CMD_HOST_DATA = 3'd2;
    localparam cmd_t CMD_HOST_STOP = 3'd3;
    // FPGA to host
    localparam cmd_t CMD_FPGA_DATA = 3'd4;
    localparam cmd_t CMD_FPGA_STOPPED = 3'd5;

    // Bit 4 set, two length bytes follow the header
    localparam len_t LEN_FOLLOWS = 5'b10000;
    // Test number, two length bytes, two count bytes
    localparam len_t START_PAYLOAD_LEN = 5'd5;

    // Test numbers
    localparam byte_t TEST_RECEIVE = 8'd0;
    localparam byte_t TEST_LOOPBACK = 8'd1;

    // ========================================
    // Error codes in STOPPED replies
    // ========================================

    localparam byte_t ERR_NONE = 8'd0;
    localparam byte_t ERR_INVALID_CMD = 8'd1;
    localparam byte_t ERR_INVALID_START_PAYLOAD = 8'd2;
    localparam byte_t ERR_INVALID_DATA_PAYLOAD = 8'd3;
    localparam byte_t ERR_INVALID_STOP_PAYLOAD = 8'd4;
    localparam byte_t ERR_STOP_PACKET_COUNT = 8'd5;
    localparam byte_t ERR_INVALID_TEST_NUM = 8'd6;
    localparam byte_t ERR_INVALID_TEST_DATA = 8'd7;

    // Largest reply, header included
    localparam int REPLY_DEPTH = 4;
    // Index into a reply buffer
    localparam int REPLY_IDX_W = $clog2(REPLY_DEPTH);

endpackage

// File: rtl/ft_test_top.sv
`timescale 1ns/100ps

module ft_test_top import ft_test_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    // Input FIFO, host to FPGA
    input  byte_t in_data_i,
    input  logic  in_empty_i,
    output logic  in_rd_en_o,
    // Output FIFO, FPGA to host
    input  logic  out_full_i,
    input  logic  out_afull_i,
    output logic  out_wr_en_o,
    output byte_t out_data_o,
    // Error LED
    output logic  err_led_o
);

    // Parser to checker
    logic hdr_valid;
    cmd_t hdr_cmd;
    len_t hdr_len;
    logic pay_valid;
    cmd_t pay_cmd;
    byte_t pay_byte;
    count_t pay_remaining;

    // Checker to writer
    logic reply_load;
    byte_t [REPLY_DEPTH-1:0] reply_bytes;
    logic halted;
    // Writer back to parser
    logic reply_busy;

    // Reader, no reads while a reply is pending
    frame_parser u_parser (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_empty_i      (in_empty_i),
        .in_data_i       (in_data_i),
        .in_rd_en_o      (in_rd_en_o),
        .hold_i          (reply_busy),
        .drain_i         (halted),
        .hdr_valid_o     (hdr_valid),
        .hdr_cmd_o       (hdr_cmd),
        .hdr_len_o       (hdr_len),
        .pay_valid_o     (pay_valid),
        .pay_cmd_o       (pay_cmd),
        .pay_byte_o      (pay_byte),
        .pay_remaining_o (pay_remaining)
    );

    // Protocol and data checks
    test_checker u_checker (
        .clk             (clk),
        .reset_i         (reset_i),
        .hdr_valid_i     (hdr_valid),
        .hdr_cmd_i       (hdr_cmd),
        .hdr_len_i       (hdr_len),
        .pay_valid_i     (pay_valid),
        .pay_cmd_i       (pay_cmd),
        .pay_byte_i      (pay_byte),
        .pay_remaining_i (pay_remaining),
        .reply_load_o    (reply_load),
        .reply_bytes_o   (reply_bytes),
        .halted_o        (halted),
        .err_led_o       (err_led_o)
    );

    // Reply output
    reply_writer u_writer (
        .clk         (clk),
        .reset_i     (reset_i),
        .load_i      (reply_load),
        .bytes_i     (reply_bytes),
        .busy_o      (reply_busy),
        .out_full_i  (out_full_i),
        .out_afull_i (out_afull_i),
        .out_wr_en_o (out_wr_en_o),
        .out_data_o  (out_data_o)
    );

endmodule

// File: rtl/reply_writer.sv
`timescale 1ns/100ps

module reply_writer import ft_test_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    // Reply from the checker
    input  logic                    load_i,
    input  byte_t [REPLY_DEPTH-1:0] bytes_i,
    output logic                    busy_o,
    // Output FIFO
    input  logic                    out_full_i,
    input  logic                    out_afull_i,
    output logic                    out_wr_en_o,
    output byte_t                   out_data_o
);

    byte_t [REPLY_DEPTH-1:0] reply_q;
    // Next byte and last byte of the reply
    logic [REPLY_IDX_W-1:0] idx;
    logic [REPLY_IDX_W-1:0] last_idx;
    logic pending;
    logic can_write;

    // Room in the output FIFO
    assign can_write = !out_full_i && !out_afull_i;

    // Busy from the load cycle on
    assign busy_o = load_i || pending;

    // ========================================
    // Write control
    // ========================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            pending <= 1'b0;
            idx <= '0;
            out_wr_en_o <= 1'b0;
        end else begin
            out_wr_en_o <= 1'b0;
            if (load_i) begin
                pending <= 1'b1;
                // Header goes out straight away if there is room
                if (can_write) begin
                    out_wr_en_o <= 1'b1;
                    idx <= REPLY_IDX_W'(1);
                end else begin
                    idx <= '0;
                end
            end else if (pending && can_write) begin
                out_wr_en_o <= 1'b1;
                idx <= idx + 1'b1;
                if (idx == last_idx) begin
                    pending <= 1'b0;
                end
            end
        end
    end

    // Reply bytes and output data
    always_ff @(posedge clk) begin
        if (load_i) begin
            reply_q <= bytes_i;
            // Length field counts bytes after the header
            last_idx <= bytes_i[0][REPLY_IDX_W-1:0];
            if (can_write) begin
                out_data_o <= bytes_i[0];
            end
        end else if (pending && can_write) begin
            out_data_o <= reply_q[idx];
        end
    end

endmodule

// File: rtl/test_checker.sv
`timescale 1ns/100ps

module test_checker import ft_test_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    // Header strobe
    input  logic                    hdr_valid_i,
    input  cmd_t                    hdr_cmd_i,
    input  len_t                    hdr_len_i,
    // Payload strobe
    input  logic                    pay_valid_i,
    input  cmd_t                    pay_cmd_i,
    input  byte_t                   pay_byte_i,
    input  count_t                  pay_remaining_i,
    // Reply to the writer, byte 0 is the header
    output logic                    reply_load_o,
    output byte_t [REPLY_DEPTH-1:0] reply_bytes_o,
    // Status
    output logic                    halted_o,
    output logic                    err_led_o
);

    // Test state
    byte_t test_num;
    count_t pkt_count;
    count_t rx_packets;
    byte_t expected;

    // Reply decision for this cycle
    logic rep_fail;
    logic rep_ok;
    logic rep_echo;
    byte_t [REPLY_DEPTH-1:0] rep_bytes;

    // Header plus up to three bytes, unused tail is zero
    function automatic byte_t [REPLY_DEPTH-1:0] make_reply(
        input cmd_t  cmd,
        input len_t  len,
        input byte_t b1,
        input byte_t b2,
        input byte_t b3
    );
        byte_t [REPLY_DEPTH-1:0] r;
        r[0] = {cmd, len};
        r[1] = b1;
        r[2] = b2;
        r[3] = b3;
        return r;
    endfunction

    // ========================================
    // Reply decision
    // ========================================

    always_comb begin
        rep_fail = 1'b0;
        rep_ok = 1'b0;
        rep_echo = 1'b0;
        rep_bytes = '0;

        if (hdr_valid_i) begin
            case (hdr_cmd_i)
                CMD_HOST_START: begin
                    if (hdr_len_i != START_PAYLOAD_LEN) begin
                        rep_fail = 1'b1;
                        // Echo the length we got
                        rep_bytes = make_reply(CMD_FPGA_STOPPED, len_t'(2),
                            ERR_INVALID_START_PAYLOAD, byte_t'(hdr_len_i), '0);
                    end
                end
                CMD_HOST_DATA: begin
                    if (hdr_len_i != LEN_FOLLOWS) begin
                        rep_fail = 1'b1;
                        rep_bytes = make_reply(CMD_FPGA_STOPPED, len_t'(2),
                            ERR_INVALID_DATA_PAYLOAD, byte_t'(hdr_len_i), '0);
                    end
                end
                CMD_HOST_STOP: begin
                    if (hdr_len_i != '0) begin
                        rep_fail = 1'b1;
                        rep_bytes = make_reply(CMD_FPGA_STOPPED, len_t'(2),
                            ERR_INVALID_STOP_PAYLOAD, byte_t'(hdr_len_i), '0);
                    end else if (rx_packets == pkt_count) begin
                        // Test passed
                        rep_ok = 1'b1;
                        rep_bytes = make_reply(CMD_FPGA_STOPPED, len_t'(1),
                            ERR_NONE, '0, '0);
                    end else begin
                        // Report packets actually seen
                        rep_fail = 1'b1;
                        rep_bytes = make_reply(CMD_FPGA_STOPPED, len_t'(3),
                            ERR_STOP_PACKET_COUNT,
                            rx_packets[COUNT_W-1:BYTE_W], rx_packets[BYTE_W-1:0]);
                    end
                end
                default: begin
                    rep_fail = 1'b1;
                    rep_bytes = make_reply(CMD_FPGA_STOPPED, len_t'(1),
                        ERR_INVALID_CMD, '0, '0);
                end
            endcase
        end else if (pay_valid_i) begin
            case (pay_cmd_i)
                CMD_HOST_START: begin
                    // First START byte is the test number
                    if (pay_remaining_i == count_t'(5) &&
                        pay_byte_i != TEST_RECEIVE && pay_byte_i != TEST_LOOPBACK) begin
                        rep_fail = 1'b1;
                        rep_bytes = make_reply(CMD_FPGA_STOPPED, len_t'(2),
                            ERR_INVALID_TEST_NUM, pay_byte_i, '0);
                    end
                end
                CMD_HOST_DATA: begin
                    if (pay_byte_i != expected) begin
                        // Actual then expected
                        rep_fail = 1'b1;
                        rep_bytes = make_reply(CMD_FPGA_STOPPED, len_t'(3),
                            ERR_INVALID_TEST_DATA, pay_byte_i, expected);
                    end else if (test_num == TEST_LOOPBACK) begin
                        rep_echo = 1'b1;
                        rep_bytes = make_reply(CMD_FPGA_DATA, len_t'(1),
                            pay_byte_i, '0, '0);
                    end
                end
                // STOP carries no payload
                default: ;
            endcase
        end
    end

    // ========================================
    // State update
    // ========================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            test_num <= TEST_RECEIVE;
            pkt_count <= '0;
            rx_packets <= '0;
            expected <= '0;
            reply_load_o <= 1'b0;
            halted_o <= 1'b0;
            err_led_o <= 1'b0;
        end else begin
            reply_load_o <= rep_fail || rep_ok || rep_echo;
            // Stays set until reset
            if (rep_fail || rep_ok) begin
                halted_o <= 1'b1;
            end
            if (rep_fail) begin
                err_led_o <= 1'b1;
            end

            if (hdr_valid_i) begin
                if (hdr_cmd_i == CMD_HOST_START) begin
                    rx_packets <= '0;
                    expected <= '0;
                end else if (hdr_cmd_i == CMD_HOST_DATA && hdr_len_i == LEN_FOLLOWS) begin
                    rx_packets <= rx_packets + count_t'(1);
                end
            end

            if (pay_valid_i) begin
                if (pay_cmd_i == CMD_HOST_START) begin
                    // Bytes 4 and 3 are the unused length
                    case (pay_remaining_i)
                        count_t'(5): test_num <= pay_byte_i;
                        count_t'(2): pkt_count[COUNT_W-1:BYTE_W] <= pay_byte_i;
                        count_t'(1): pkt_count[BYTE_W-1:0] <= pay_byte_i;
                        default: ;
                    endcase
                end else if (pay_cmd_i == CMD_HOST_DATA && pay_byte_i == expected) begin
                    expected <= expected + byte_t'(1);
                end
            end
        end
    end

    // Reply buffer
    always_ff @(posedge clk) begin
        if (rep_fail || rep_ok || rep_echo) begin
            reply_bytes_o <= rep_bytes;
        end
    end

endmodule

// File: test/ft_test_tb.sv
`timescale 1ns/100ps

module ft_test_tb import ft_test_pkg::*; ();

    // Idle output cycles that close a scenario
    localparam int QUIET_CYCLES = 100;
    // Wait limits in clock cycles
    localparam int DRAIN_LIMIT = 4000;
    localparam int REPLY_LIMIT = 2000;

    logic clk;
    logic reset_i;
    byte_t in_data_i;
    logic in_empty_i;
    logic in_rd_en_o;
    logic out_full_i;
    logic out_afull_i;
    logic out_wr_en_o;
    byte_t out_data_o;
    logic err_led_o;

    // Host bytes still in the input FIFO
    byte_t host_q[$];
    // Reply bytes still to see
    byte_t exp_q[$];

    integer seed = 8;
    integer fd;
    int error_count;
    int timeout_count;
    int quiet_cycles;
    // Back-pressure seen by the DUT when it chose to write
    logic blocked_q;
    // LED state at the end of the scenario
    logic led_exp;

    ft_test_top UUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_data_i   (in_data_i),
        .in_empty_i  (in_empty_i),
        .in_rd_en_o  (in_rd_en_o),
        .out_full_i  (out_full_i),
        .out_afull_i (out_afull_i),
        .out_wr_en_o (out_wr_en_o),
        .out_data_o  (out_data_o),
        .err_led_o   (err_led_o)
    );

    always #5 clk = ~clk;

    // ========================================
    // FIFO models
    // ========================================

    // Show-ahead input FIFO whose front byte stays up until read
    always @(posedge clk) begin
        byte_t dropped;
        if (in_rd_en_o && host_q.size() > 0) begin
            dropped = host_q.pop_front();
        end
        if (host_q.size() > 0) begin
            in_data_i <= host_q[0];
            in_empty_i <= 1'b0;
        end else begin
            in_data_i <= '0;
            in_empty_i <= 1'b1;
        end
    end

    // Almost full about one cycle in four
    // Full about one cycle in eight
    always @(posedge clk) begin
        out_afull_i <= ($random(seed) & 3) == 0;
        out_full_i <= ($random(seed) & 7) == 0;
    end

    // Output collector that checks bytes in order
    always @(posedge clk) begin
        byte_t exp_byte;
        blocked_q <= out_full_i || out_afull_i;
        if (out_wr_en_o) begin
            quiet_cycles <= 0;
            assert (!blocked_q) else begin
                error_count++;
                $display("[FAIL] %0t: byte %h written while the output FIFO was full",
                    $time, out_data_o);
            end
            assert (exp_q.size() > 0) else begin
                error_count++;
                $display("[FAIL] %0t: unexpected output byte %h", $time, out_data_o);
            end
            if (exp_q.size() > 0) begin
                exp_byte = exp_q.pop_front();
                assert (out_data_o == exp_byte) else begin
                    error_count++;
                    $display("[FAIL] %0t: output byte %h, expected %h",
                        $time, out_data_o, exp_byte);
                end
            end
        end else if (reset_i) begin
            quiet_cycles <= 0;
        end else if (quiet_cycles < QUIET_CYCLES) begin
            quiet_cycles <= quiet_cycles + 1;
        end
    end

    // ========================================
    // Trace reader
    // ========================================

    function automatic logic [3:0] hex_digit(input byte ch);
        logic [3:0] v;
        if (ch >= "0" && ch <= "9") begin
            v = 4'(ch - "0");
        end else if (ch >= "a" && ch <= "f") begin
            v = 4'(ch - "a" + 10);
        end else begin
            v = 4'(ch - "A" + 10);
        end
        return v;
    endfunction

    // Next blank-separated token with len 0 at end of file
    task automatic read_token(output int len, output byte t0, output byte t1);
        int c;
        len = 0;
        t0 = 0;
        t1 = 0;
        c = $fgetc(fd);
        // Skip blanks and comment lines
        while (c == " " || c == "\t" || c == "\n" || c == "\r" || c == "#") begin
            if (c == "#") begin
                while (c != "\n" && c != -1) c = $fgetc(fd);
            end
            c = $fgetc(fd);
        end
        while (c != -1 && c != " " && c != "\t" && c != "\n" && c != "\r") begin
            if (len == 0) begin
                t0 = c[7:0];
            end else begin
                t1 = c[7:0];
            end
            len++;
            c = $fgetc(fd);
        end
    endtask

    // Loads one scenario into the queues and leaves found low at end of file
    task automatic load_scenario(output bit found);
        int len;
        int left;
        byte t0;
        byte t1;
        byte kind;
        byte_t value;
        byte_t hdr;
        byte_t code;
        bit code_next;
        bit ended;
        found = 1'b0;
        ended = 1'b0;
        kind = 0;
        left = 0;
        hdr = '0;
        code = ERR_NONE;
        code_next = 1'b0;
        while (!ended) begin
            read_token(len, t0, t1);
            if (len == 0) begin
                ended = 1'b1;
            end else if (len == 1 && t0 == "S") begin
                ended = 1'b1;
                found = 1'b1;
            end else if (len == 1) begin
                kind = t0;
            end else if (len == 2 && kind == "H") begin
                host_q.push_back({hex_digit(t0), hex_digit(t1)});
                found = 1'b1;
            end else if (len == 2 && kind == "E") begin
                value = {hex_digit(t0), hex_digit(t1)};
                exp_q.push_back(value);
                found = 1'b1;
                // Follow reply framing to find the last header and its code
                if (left == 0) begin
                    hdr = value;
                    code = ERR_NONE;
                    left = value[LEN_W-1:0];
                    code_next = 1'b1;
                end else begin
                    if (code_next) code = value;
                    code_next = 1'b0;
                    left--;
                end
            end else begin
                error_count++;
                $display("Trace file holds a token that is not a kind or a hex byte");
            end
        end
        // LED on only after a STOPPED reply with an error code
        led_exp = (hdr[BYTE_W-1 -: CMD_W] == CMD_FPGA_STOPPED) && (code != ERR_NONE);
    endtask

    // ========================================
    // Scenario control
    // ========================================

    // Ten reset cycles with the queues refilled while reset is high
    task automatic start_scenario(output bit found);
        @(posedge clk);
        reset_i <= 1'b1;
        @(posedge clk);
        host_q.delete();
        exp_q.delete();
        load_scenario(found);
        repeat (9) @(posedge clk);
        reset_i <= 1'b0;
    endtask

    task automatic run_scenario(input int n);
        int cycles;
        cycles = 0;
        // All host bytes read
        while (host_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (host_q.size() != 0) begin
            timeout_count++;
            $display("Scenario %0d: timed out waiting for the DUT to read %0d host bytes",
                n, host_q.size());
        end
        // Every reply byte seen and then a quiet output
        cycles = 0;
        while ((exp_q.size() != 0 || quiet_cycles < QUIET_CYCLES) && cycles < REPLY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0 || quiet_cycles < QUIET_CYCLES) begin
            timeout_count++;
            $display("Scenario %0d: timed out waiting for %0d reply bytes and a quiet output",
                n, exp_q.size());
        end
        assert (err_led_o == led_exp) else begin
            error_count++;
            $display("[FAIL] %0t: scenario %0d error LED is %0b, expected %0b",
                $time, n, err_led_o, led_exp);
        end
    endtask

    initial begin
        int scenario;
        bit found;
        clk = 1'b0;
        reset_i = 1'b1;
        in_data_i = '0;
        in_empty_i = 1'b1;
        out_full_i = 1'b0;
        out_afull_i = 1'b0;
        error_count = 0;
        timeout_count = 0;
        scenario = 0;
        found = 1'b1;
        fd = $fopen("test/ft_test_trace.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the trace file test/ft_test_trace.txt");
            found = 1'b0;
        end
        while (found) begin
            start_scenario(found);
            if (found) begin
                scenario++;
                run_scenario(scenario);
            end
        end
        if (fd != 0) $fclose(fd);
        $display("Scenarios: %0d, errors: %0d, timeouts: %0d",
            scenario, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: test/ft_test_trace.txt
# Kind letter then hex bytes: H host bytes to send, E expected reply bytes
# S ends a scenario, the DUT is reset before each scenario
# Receive test, two packets carry bytes 0 to 5
H 25 00 00 00 00 02
H 50 00 04 00 01 02 03
H 50 00 02 04 05
H 60
E A1 00
S
# Loopback test, every byte echoed
H 25 01 00 00 00 02
H 50 00 03 00 01 02
H 50 00 03 03 04 05
H 60
E 81 00 81 01 81 02
E 81 03 81 04 81 05
E A1 00
S
# Wrong third data byte, rest is drained
H 25 00 00 00 00 02
H 50 00 03 00 01 5A
H 50 00 03 03 04 05
H 60
E A3 07 5A 02
S
# START with length 4
H 24 00 00 00 02
H 60
E A2 02 04
S
# Unknown command 6
H C0
H 60
E A1 01
S
# Test number 2
H 25 02 00 00 00 01
H 50 00 01 00
H 60
E A2 06 02
S
# DATA with short length 3
H 25 00 00 00 00 01
H 43 00 01 02
H 60
E A2 03 03
S
# STOP after 1 of 3 packets
H 25 00 00 00 00 03
H 50 00 02 00 01
H 60
E A3 05 00 01
S
# STOP with length 1
H 25 00 00 00 00 00
H 61 00
E A2 04 01
S
